// File: build.f
design/soc_pkg.sv
design/reset_hold.sv
design/input_debounce.sv
design/seg_scan.sv
design/dev_decoder.sv
design/board_regs.sv
design/soc_board_top.sv
tests/tb_soc_board.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_soc_board -f build.f -o tb_soc_board_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/tb_soc_board_sim
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi
exit 0

// File: tests/tb_soc_board.sv
`timescale 1ns/100ps
`default_nettype none

module tb_soc_board import soc_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int N_RW = 40;
	localparam int N_BAD = 16;
	localparam int N_UNLISTED = 12;
	localparam int N_INPUT = 12;
	localparam int N_IRQ = 8;
	localparam int N_TXN = 1 + 2 * N_RW + N_BAD + 2 * N_UNLISTED + 4 * N_INPUT + 7 * N_IRQ;
	localparam int RSP_LIMIT = RESET_HOLD_CYCLES + 8;
	localparam int SETTLE = DEBOUNCE_CYCLES + 4;

	logic clk_cpu;
	logic rst_n_i;
	bus_req_t bus_req;
	bus_rsp_t bus_rsp;
	board_in_t board_raw;
	logic [7:0] led;
	logic [7:0] segment;
	logic [3:0] anode;
	logic irq;

	logic [31:0] lcg_state;
	logic [7:0] led_m;
	logic [19:0] disp_m;
	logic [3:0] en_m;
	logic [3:0] pend_m;
	board_in_t in_m;
	logic mon_en;
	int scan_digit;
	int scan_run;
	logic scan_sync;

	soc_board_top u_soc_board_top (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.bus_i(bus_req),
		.bus_o(bus_rsp),
		.board_i(board_raw),
		.led_o(led),
		.segment_o(segment),
		.anode_o(anode),
		.irq_o(irq)
	);

	initial begin
		clk_cpu = 1'b0;
		forever #(CLK_PERIOD / 2) clk_cpu = ~clk_cpu;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	// budget of 64 cycles per transaction plus the hold-off
	initial begin
		#(CLK_PERIOD * (N_TXN * 64 + RESET_HOLD_CYCLES + 10));
		fail_run("the run timed out before all tests finished");
	end

	function automatic logic [31:0] next_random();
		logic [15:0] hi_a;
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		hi_a = lcg_state[31:16];
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {hi_a, lcg_state[31:16]};
	endfunction

	function automatic logic [31:0] apply_sel(input logic [31:0] old_w, input logic [31:0] new_w,
		input logic [3:0] sel);
		logic [31:0] mask;
		mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	// register read value as the model sees it
	function automatic logic [31:0] model_value(input logic [7:0] off);
		case (off)
			REG_SWITCH: return {20'h0, in_m};
			REG_LED: return {24'h0, led_m};
			REG_DISPLAY: return {12'h0, disp_m};
			REG_IRQ_PEND: return {28'h0, pend_m};
			REG_IRQ_EN: return {28'h0, en_m};
			default: return 32'h0;
		endcase
	endfunction

	function automatic logic [7:0] expected_segment(input int k);
		logic [3:0] digit;
		digit = disp_m[4*k +: 4];
		return {~disp_m[16 + k], SEG_FONT[digit]};
	endfunction

	// index of the single low anode bit, or -1
	function automatic int active_digit(input logic [3:0] an);
		int idx;
		int lows;
		idx = -1;
		lows = 0;
		for (int b = 0; b < 4; b++) begin
			if (an[b] === 1'b0) begin
				lows++;
				idx = b;
			end
		end
		return (lows == 1) ? idx : -1;
	endfunction

	function automatic bus_rsp_t make_rsp(input logic ack, input logic err, input logic [31:0] dat);
		bus_rsp_t r;
		r.ack = ack;
		r.err = err;
		r.dat = dat;
		return r;
	endfunction

	task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input logic with_dat);
		if (got.ack !== exp.ack)
			fail_run($sformatf("ERROR bus_o.ack got %h exp %h", got.ack, exp.ack));
		if (got.err !== exp.err)
			fail_run($sformatf("ERROR bus_o.err got %h exp %h", got.err, exp.err));
		if (with_dat && got.dat !== exp.dat)
			fail_run($sformatf("ERROR bus_o.dat got %h exp %h", got.dat, exp.dat));
	endtask

	task automatic check_outputs(input logic [7:0] led_got, input logic [7:0] led_exp,
		input logic [7:0] seg_got, input logic [7:0] seg_exp,
		input logic [3:0] an_got, input logic [3:0] an_exp);
		if (an_got !== an_exp)
			fail_run($sformatf("ERROR anode_o got %h exp %h", an_got, an_exp));
		if (led_got !== led_exp)
			fail_run($sformatf("ERROR led_o got %h exp %h", led_got, led_exp));
		if (seg_got !== seg_exp)
			fail_run($sformatf("ERROR segment_o got %h exp %h anode_o %h", seg_got, seg_exp,
				an_got));
	endtask

	task automatic check_irq(input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("ERROR irq_o got %h exp %h", got, exp));
	endtask

	task automatic start_req(input logic we, input logic [7:0] slot, input logic [5:0] word,
		input logic [31:0] dat, input logic [3:0] sel);
		bus_req.cyc = 1'b1;
		bus_req.stb = 1'b1;
		bus_req.we = we;
		bus_req.sel = sel;
		bus_req.adr = {slot, word};
		bus_req.dat = dat;
	endtask

	// sample after each edge until ack or err is seen
	task automatic wait_rsp(output bus_rsp_t rsp, output int cycles);
		cycles = 0;
		do begin
			@(posedge clk_cpu);
			#1;
			cycles++;
			rsp = bus_rsp;
			if (!rsp.ack && !rsp.err && cycles >= RSP_LIMIT)
				fail_run($sformatf("no bus response within %0d cycles", RSP_LIMIT));
		end while (!rsp.ack && !rsp.err);
	endtask

	// stb still held here, the response must already be gone
	task automatic end_req();
		@(posedge clk_cpu);
		#1;
		check_rsp(bus_rsp, make_rsp(1'b0, 1'b0, 32'h0), 1'b0);
		#1;
		bus_req.cyc = 1'b0;
		bus_req.stb = 1'b0;
	endtask

	task automatic bus_access(input logic we, input logic [7:0] slot, input logic [5:0] word,
		input logic [31:0] dat, input logic [3:0] sel, input bus_rsp_t exp, input logic with_dat);
		bus_rsp_t rsp;
		int cycles;
		@(posedge clk_cpu);
		#2;
		start_req(we, slot, word, dat, sel);
		wait_rsp(rsp, cycles);
		check_rsp(rsp, exp, with_dat);
		if (cycles != 1)
			fail_run($sformatf("ERROR response latency got %h exp %h", cycles, 1));
	endtask

	task automatic write_board(input logic [7:0] off, input logic [31:0] dat, input logic [3:0] sel);
		logic [31:0] merged;
		bus_access(1'b1, SLOT_BOARD, off[7:2], dat, sel, make_rsp(1'b1, 1'b0, 32'h0), 1'b0);
		merged = apply_sel(model_value(off), dat, sel);
		case (off)
			REG_LED: led_m = merged[7:0];
			REG_DISPLAY: disp_m = merged[19:0];
			REG_IRQ_EN: en_m = merged[3:0];
			// write one to clear, low byte only
			REG_IRQ_PEND: pend_m = sel[0] ? (pend_m & ~dat[3:0]) : pend_m;
			default: ;
		endcase
		end_req();
	endtask

	task automatic read_board(input logic [7:0] off);
		bus_access(1'b0, SLOT_BOARD, off[7:2], 32'h0, 4'hF,
			make_rsp(1'b1, 1'b0, model_value(off)), 1'b1);
		end_req();
	endtask

	task automatic settle_inputs(input board_in_t val);
		@(posedge clk_cpu);
		#2;
		board_raw = val;
		repeat (SETTLE) @(posedge clk_cpu);
		pend_m = pend_m | (val.btn & ~in_m.btn);
		in_m = val;
	endtask

	task automatic glitch_inputs(input board_in_t val, input int len);
		@(posedge clk_cpu);
		#2;
		board_raw = val;
		repeat (len) @(posedge clk_cpu);
		#2;
		board_raw = in_m;
		repeat (SETTLE) @(posedge clk_cpu);
	endtask

	// scan model locks to the first digit change it sees
	always @(negedge clk_cpu) begin
		int k;
		if (mon_en) begin
			k = active_digit(anode);
			if (k < 0)
				fail_run($sformatf("ERROR anode_o got %h exp one low bit", anode));
			if (scan_sync) begin
				scan_run++;
				if (scan_run > SCAN_CYCLES) begin
					scan_digit = (scan_digit + 1) % 4;
					scan_run = 1;
				end
			end else begin
				if (scan_digit >= 0 && k != scan_digit) begin
					scan_sync = 1'b1;
					scan_run = 1;
				end
				scan_digit = k;
			end
			check_outputs(led, led_m, segment, expected_segment(scan_digit), anode,
				~(4'b0001 << scan_digit));
		end
	end

	initial begin
		bus_rsp_t rsp;
		int cycles;
		int k;
		board_in_t val;
		logic [11:0] cur_bits;
		logic [31:0] rnd;
		logic [31:0] rnd2;
		logic [7:0] slot;
		logic [7:0] off;

		lcg_state = 32'd33;
		rst_n_i = 1'b0;
		bus_req = '0;
		board_raw = '0;
		led_m = '0;
		disp_m = '0;
		en_m = '0;
		pend_m = '0;
		in_m = '0;
		mon_en = 1'b0;
		scan_digit = -1;
		scan_run = 0;
		scan_sync = 1'b0;
		repeat (10) @(posedge clk_cpu);
		#2;
		check_rsp(bus_rsp, make_rsp(1'b0, 1'b0, 32'h0), 1'b0);
		check_irq(irq, 1'b0);
		check_outputs(led, 8'h00, segment, expected_segment(0), anode, 4'b1110);

		// request goes out in the same step as the reset release
		rst_n_i = 1'b1;
		start_req(1'b0, SLOT_BOARD, REG_LED[7:2], 32'h0, 4'hF);
		wait_rsp(rsp, cycles);
		if (cycles <= RESET_HOLD_CYCLES)
			fail_run($sformatf("a read during the reset hold-off was answered after %0d cycles",
				cycles));
		check_rsp(rsp, make_rsp(1'b1, 1'b0, 32'h0), 1'b1);
		end_req();
		mon_en = 1'b1;

		for (int i = 0; i < N_RW; i++) begin
			k = int'(next_random() % 32'd3);
			off = (k == 0) ? REG_LED : ((k == 1) ? REG_DISPLAY : REG_IRQ_EN);
			rnd = next_random();
			rnd2 = next_random();
			write_board(off, rnd, rnd2[3:0]);
			read_board(off);
		end

		for (int i = 0; i < N_BAD; i++) begin
			rnd = next_random();
			rnd2 = next_random();
			slot = rnd[15:8];
			if (slot == SLOT_BOARD)
				slot = slot + 8'd1;
			bus_access(rnd[0], slot, rnd[7:2], rnd2, rnd[19:16], make_rsp(1'b0, 1'b1, 32'h0), 1'b1);
			end_req();
		end

		// word offsets 5 and up hold no register
		for (int i = 0; i < N_UNLISTED; i++) begin
			k = 5 + int'(next_random() % 32'd59);
			off = 8'(k * 4);
			write_board(off, next_random(), 4'hF);
			read_board(off);
		end

		for (int i = 0; i < N_INPUT; i++) begin
			rnd = next_random();
			val = rnd[11:0];
			settle_inputs(val);
			read_board(REG_SWITCH);
			rnd = next_random();
			cur_bits = in_m;
			val = cur_bits ^ (rnd[11:0] | 12'h001);
			glitch_inputs(val, 1 + int'(rnd[31:28]) % (DEBOUNCE_CYCLES - 1));
			read_board(REG_SWITCH);
		end

		for (int i = 0; i < N_IRQ; i++) begin
			k = i % BUTTON_BITS;
			rnd = next_random();
			write_board(REG_IRQ_EN, (i < BUTTON_BITS) ? 32'hF : rnd, 4'h1);
			val = in_m;
			val.btn = '0;
			settle_inputs(val);
			write_board(REG_IRQ_PEND, 32'hF, 4'h1);
			check_irq(irq, 1'b0);
			val.btn[k] = 1'b1;
			settle_inputs(val);
			read_board(REG_IRQ_PEND);
			check_irq(irq, |(pend_m & en_m));
			write_board(REG_IRQ_PEND, 32'h1 << k, 4'h1);
			check_irq(irq, |(pend_m & en_m));
			read_board(REG_IRQ_PEND);
		end

		repeat (4) @(posedge clk_cpu);
		if (!scan_sync) begin
			fail_run("the display scan never moved on to the next digit");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: design/soc_board_top.sv
`timescale 1ns/100ps
`default_nettype none

module soc_board_top import soc_pkg::*; (
	input logic clk_cpu,
	input logic rst_n_i,
	input bus_req_t bus_i,
	output bus_rsp_t bus_o,
	input board_in_t board_i,
	output logic [7:0] led_o,
	output logic [7:0] segment_o,
	output logic [3:0] anode_o,
	output logic irq_o
);

	logic sys_rst_n;
	board_in_t board_clean;
	dev_req_t board_req;
	dev_rsp_t board_rsp;

	reset_hold u_reset_hold (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.sys_rst_n_o(sys_rst_n)
	);

	input_debounce u_input_debounce (
		.clk_cpu(clk_cpu),
		.rst_n_i(sys_rst_n),
		.raw_i(board_i),
		.clean_o(board_clean)
	);

	dev_decoder u_dev_decoder (
		.clk_cpu(clk_cpu),
		.rst_n_i(sys_rst_n),
		.bus_i(bus_i),
		.bus_o(bus_o),
		.board_req_o(board_req),
		.board_rsp_i(board_rsp)
	);

	// board device in slot 2
	board_regs u_board_regs (
		.clk_cpu(clk_cpu),
		.rst_n_i(sys_rst_n),
		.req_i(board_req),
		.rsp_o(board_rsp),
		.inputs_i(board_clean),
		.led_o(led_o),
		.irq_o(irq_o),
		.segment_o(segment_o),
		.anode_o(anode_o)
	);

endmodule

`default_nettype wire

// File: design/board_regs.sv
`timescale 1ns/100ps
`default_nettype none

module board_regs import soc_pkg::*; (
	input logic clk_cpu,
	input logic rst_n_i,
	input dev_req_t req_i,
	output dev_rsp_t rsp_o,
	input board_in_t inputs_i,
	output logic [7:0] led_o,
	output logic irq_o,
	output logic [7:0] segment_o,
	output logic [3:0] anode_o
);

	logic ack_q;
	logic access;
	logic wr_en;
	logic [7:0] led_q;
	logic [19:0] disp_q;
	logic [BUTTON_BITS-1:0] en_q;
	logic [BUTTON_BITS-1:0] pend_q;
	logic [BUTTON_BITS-1:0] btn_q;
	logic [BUTTON_BITS-1:0] btn_rise;
	logic [BUTTON_BITS-1:0] pend_clr;
	logic [31:0] cur_word;
	logic [31:0] merged;
	logic [31:0] rdata_q;

	function automatic logic [31:0] byte_merge(
		input logic [31:0] old_w,
		input logic [31:0] new_w,
		input logic [3:0] sel
	);
		logic [31:0] res;
		res = old_w;
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				res[8*i +: 8] = new_w[8*i +: 8];
			end
		end
		return res;
	endfunction

	// ack stays one cycle although cs is still held
	assign access = req_i.cs & ~ack_q;
	assign wr_en = access & req_i.we;
	assign btn_rise = inputs_i.btn & ~btn_q;

	// current register value, zero outside defined fields
	always_comb begin
		case (req_i.adr)
			REG_SWITCH[7:2]: cur_word = {20'h0, inputs_i};
			REG_LED[7:2]: cur_word = {24'h0, led_q};
			REG_DISPLAY[7:2]: cur_word = {12'h0, disp_q};
			REG_IRQ_PEND[7:2]: cur_word = {28'h0, pend_q};
			REG_IRQ_EN[7:2]: cur_word = {28'h0, en_q};
			default: cur_word = 32'h0;
		endcase
	end

	assign merged = byte_merge(cur_word, req_i.dat, req_i.sel);

	// write one to clear
	assign pend_clr = (wr_en && req_i.adr == REG_IRQ_PEND[7:2] && req_i.sel[0]) ?
		req_i.dat[BUTTON_BITS-1:0] : '0;

	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
			led_q <= '0;
			disp_q <= '0;
			en_q <= '0;
			pend_q <= '0;
			btn_q <= '0;
		end else begin
			ack_q <= access;
			btn_q <= inputs_i.btn;
			// a new press wins over a clear in the same cycle
			pend_q <= (pend_q & ~pend_clr) | btn_rise;
			if (wr_en) begin
				case (req_i.adr)
					REG_LED[7:2]: led_q <= merged[7:0];
					REG_DISPLAY[7:2]: disp_q <= merged[19:0];
					REG_IRQ_EN[7:2]: en_q <= merged[BUTTON_BITS-1:0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (access) begin
			rdata_q <= cur_word;
		end
	end

	assign rsp_o = '{ack: ack_q, dat: rdata_q};
	assign led_o = led_q;
	assign irq_o = |(pend_q & en_q);

	seg_scan u_seg_scan (
		.clk_cpu(clk_cpu),
		.rst_n_i(rst_n_i),
		.digits_i(disp_q[15:0]),
		.dots_i(disp_q[19:16]),
		.segment_o(segment_o),
		.anode_o(anode_o)
	);

endmodule

`default_nettype wire

// File: design/dev_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module dev_decoder import soc_pkg::*; (
	input logic clk_cpu,
	input logic rst_n_i,
	input bus_req_t bus_i,
	output bus_rsp_t bus_o,
	output dev_req_t board_req_o,
	input dev_rsp_t board_rsp_i
);

	logic [SLOT_BITS-1:0] slot;
	logic req_valid;
	logic board_hit;
	logic err_q;

	assign slot = bus_i.adr[DEV_TOTAL_ADDR_BITS-1:DEV_SLOT_ADDR_BITS];
	assign req_valid = bus_i.cyc & bus_i.stb;
	assign board_hit = req_valid & (slot == SLOT_BOARD);

	always_comb begin
		board_req_o.cs = board_hit;
		board_req_o.we = bus_i.we;
		board_req_o.sel = bus_i.sel;
		board_req_o.adr = bus_i.adr[DEV_SLOT_ADDR_BITS-1:2];
		board_req_o.dat = bus_i.dat;
	end

	// unmapped slot, one-cycle err
	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			err_q <= 1'b0;
		end else begin
			err_q <= req_valid & ~board_hit & ~err_q;
		end
	end

	always_comb begin
		bus_o.ack = board_rsp_i.ack;
		bus_o.err = err_q;
		bus_o.dat = board_rsp_i.ack ? board_rsp_i.dat : 32'h0;
	end

endmodule

`default_nettype wire

// File: design/seg_scan.sv
`timescale 1ns/100ps
`default_nettype none

module seg_scan import soc_pkg::*; (
	input logic clk_cpu,
	input logic rst_n_i,
	input logic [15:0] digits_i,
	input logic [3:0] dots_i,
	output logic [7:0] segment_o,
	output logic [3:0] anode_o
);

	localparam int PRE_W = (SCAN_CYCLES > 1) ? $clog2(SCAN_CYCLES) : 1;

	logic [PRE_W-1:0] pre_cnt;
	logic [1:0] digit_idx;
	logic [3:0] nibble;

	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pre_cnt <= '0;
			digit_idx <= 2'd0;
		end else if (pre_cnt == PRE_W'(SCAN_CYCLES - 1)) begin
			pre_cnt <= '0;
			digit_idx <= digit_idx + 2'd1;
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
		end
	end

	assign nibble = digits_i[4*digit_idx +: 4];

	// one anode low at a time
	assign anode_o = ~(4'b0001 << digit_idx);

	// dot is bit 7, active low like the segments
	assign segment_o = {~dots_i[digit_idx], SEG_FONT[nibble]};

endmodule

`default_nettype wire

// File: design/input_debounce.sv
`timescale 1ns/100ps
`default_nettype none

module input_debounce import soc_pkg::*; (
	input logic clk_cpu,
	input logic rst_n_i,
	input board_in_t raw_i,
	output board_in_t clean_o
);

	localparam int NBITS = SWITCH_BITS + BUTTON_BITS;
	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic [NBITS-1:0] raw_vec;
	logic [NBITS-1:0] raw_q;
	logic [NBITS-1:0] clean_q;
	logic [CNT_W-1:0] stable_cnt [NBITS];

	assign raw_vec = raw_i;
	assign clean_o = clean_q;

	// stable_cnt holds how many cycles in a row the bit has kept raw_q
	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			raw_q <= '0;
			clean_q <= '0;
			for (int i = 0; i < NBITS; i++) begin
				stable_cnt[i] <= '0;
			end
		end else begin
			raw_q <= raw_vec;
			for (int i = 0; i < NBITS; i++) begin
				if (raw_vec[i] != raw_q[i]) begin
					stable_cnt[i] <= CNT_W'(1);
				end else begin
					if (stable_cnt[i] != CNT_W'(DEBOUNCE_CYCLES)) begin
						stable_cnt[i] <= stable_cnt[i] + 1'b1;
					end
					// last of the required cycles
					if (stable_cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
						clean_q[i] <= raw_vec[i];
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: design/reset_hold.sv
`timescale 1ns/100ps
`default_nettype none

module reset_hold import soc_pkg::*; (
	input logic clk_cpu,
	input logic rst_n_i,
	output logic sys_rst_n_o
);

	localparam int CNT_W = $clog2(RESET_HOLD_CYCLES + 1);

	logic [CNT_W-1:0] hold_cnt;

	// count edges since release, let go on the last one
	always_ff @(posedge clk_cpu or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hold_cnt <= '0;
			sys_rst_n_o <= 1'b0;
		end else begin
			if (hold_cnt != CNT_W'(RESET_HOLD_CYCLES)) begin
				hold_cnt <= hold_cnt + 1'b1;
			end
			if (hold_cnt == CNT_W'(RESET_HOLD_CYCLES - 1)) begin
				sys_rst_n_o <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/soc_pkg.sv
`default_nettype none

package soc_pkg;

	// device window and slot span
	localparam int DEV_TOTAL_ADDR_BITS = 16;
	localparam int DEV_SLOT_ADDR_BITS = 8;
	localparam int SLOT_BITS = DEV_TOTAL_ADDR_BITS - DEV_SLOT_ADDR_BITS;

	localparam logic [SLOT_BITS-1:0] SLOT_BOARD = 8'd2;

	// board register byte offsets
	localparam logic [7:0] REG_SWITCH = 8'h00;
	localparam logic [7:0] REG_LED = 8'h04;
	localparam logic [7:0] REG_DISPLAY = 8'h08;
	localparam logic [7:0] REG_IRQ_PEND = 8'h0C;
	localparam logic [7:0] REG_IRQ_EN = 8'h10;

	localparam int RESET_HOLD_CYCLES = 16;
	localparam int DEBOUNCE_CYCLES = 8;
	localparam int SCAN_CYCLES = 4;

	localparam int SWITCH_BITS = 8;
	localparam int BUTTON_BITS = 4;

	// active low, order g f e d c b a
	localparam logic [6:0] SEG_FONT [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30,
		7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03,
		7'h46, 7'h21, 7'h06, 7'h0E
	};

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [3:0] sel;
		logic [DEV_TOTAL_ADDR_BITS-1:2] adr;
		logic [31:0] dat;
	} bus_req_t;

	typedef struct packed {
		logic ack;
		logic err;
		logic [31:0] dat;
	} bus_rsp_t;

	// word offset inside one slot
	typedef struct packed {
		logic cs;
		logic we;
		logic [3:0] sel;
		logic [DEV_SLOT_ADDR_BITS-1:2] adr;
		logic [31:0] dat;
	} dev_req_t;

	typedef struct packed {
		logic ack;
		logic [31:0] dat;
	} dev_rsp_t;

	// buttons above switches, same layout as the switch register
	typedef struct packed {
		logic [BUTTON_BITS-1:0] btn;
		logic [SWITCH_BITS-1:0] sw;
	} board_in_t;

endpackage

`default_nettype wire
